// File: common/shift_macros.svh
`ifndef SHIFT_MACROS_SVH
`define SHIFT_MACROS_SVH

// ====================
// datapath widths
// ====================

`define SHIFT_WIDTH  64  // operand and result
`define SHIFT_CNT_W  6   // shift count, enough for 0..63
`define SHIFT_BYTE_W 8   // byte shifter

`endif

// File: common/shift_unit_pkg.sv
package shift_unit_pkg;

  // ====================
  // operation codes
  // ====================

  typedef enum logic [1:0] {
    op_shl = 2'd0,  // logical left
    op_shr = 2'd1,  // logical right
    op_sar = 2'd2   // arithmetic right
  } shift_op_e;

  // ====================
  // operand sizes
  // ====================

  // no 16-bit size in this unit
  typedef enum logic [1:0] {
    size_8  = 2'd0,
    size_32 = 2'd1,
    size_64 = 2'd2
  } op_size_e;

endpackage

// File: hw/shift_decode.sv
`timescale 1ns/100ps
`include "shift_macros.svh"

module shift_decode (
  input  shift_unit_pkg::shift_op_e  op,
  input  shift_unit_pkg::op_size_e   size,
  input  logic [`SHIFT_CNT_W-1:0]    count,
  output logic                       dir,
  output logic                       arith,
  output logic                       en_32,
  output logic                       en_64,
  output logic [`SHIFT_CNT_W-1:0]    cnt_m
);

  // ====================
  // operation
  // ====================

  always_comb begin
    case (op)
      shift_unit_pkg::op_shr: begin
        dir   = 1'b1;
        arith = 1'b0;
      end
      shift_unit_pkg::op_sar: begin
        dir   = 1'b1;
        arith = 1'b1;  // fill with sign
      end
      default: begin
        dir   = 1'b0;  // left shift, zero fill
        arith = 1'b0;
      end
    endcase
  end

  // ====================
  // size and count mask
  // ====================

  always_comb begin
    en_32 = 1'b0;
    en_64 = 1'b0;
    cnt_m = {1'b0, count[`SHIFT_CNT_W-2:0]};  // 5-bit count as on x86
    case (size)
      shift_unit_pkg::size_32: en_32 = 1'b1;
      shift_unit_pkg::size_64: begin
        en_64 = 1'b1;
        cnt_m = count;  // full 6-bit count
      end
      default: ;  // byte ops go through the byte shifter
    endcase
  end

endmodule

// File: hw/shifter/shift_wide.sv
`timescale 1ns/100ps
`include "shift_macros.svh"

module shift_wide (
  input  logic                      dir,
  input  logic                      arith,
  input  logic                      en_32,
  input  logic                      en_64,
  input  logic [`SHIFT_WIDTH-1:0]   operand,
  input  logic [`SHIFT_CNT_W-1:0]   cnt_m,
  output logic [`SHIFT_WIDTH-1:0]   wide_res,
  output logic                      carry_r,
  output logic                      carry_l64,
  output logic                      carry_l32
);

  localparam int W     = `SHIFT_WIDTH;
  localparam int HALF  = W / 2;
  localparam int XW    = 2 * W + 8;  // guard byte plus a full operand of fill
  localparam int NB_R  = W / 8 + 2;  // bytes kept after the right byte stage
  localparam int NB_L  = W / 8 + 1;  // bytes kept after the left byte stage

  logic            fill;
  logic [W-1:0]    val_p;
  logic [2:0]      byte_sel;
  logic [2:0]      bit_sel;

  logic [XW-1:0]   ext_r;
  logic [XW-1:0]   ext_l;
  logic [W+15:0]   stg_r;   // guard byte below, one byte of fill above
  logic [W+15:0]   sh_r;
  logic [W+7:0]    stg_l;   // one carry byte above
  logic [W+7:0]    sh_l;
  logic [W-1:0]    res_raw;

  assign byte_sel = cnt_m[`SHIFT_CNT_W-1:3];
  assign bit_sel  = cnt_m[2:0];

  // ====================
  // fill and operand
  // ====================

  // sign comes from bit 63 for quadwords, bit 31 otherwise
  assign fill = arith & (en_64 ? operand[W-1] : operand[HALF-1]);

  // a 32-bit right shift must pull fill into bit 31, not the upper half
  assign val_p[HALF-1:0] = operand[HALF-1:0];
  assign val_p[W-1:HALF] = en_64 ? operand[W-1:HALF] : {HALF{fill}};

  // ====================
  // right shift
  // ====================

  // val_p sits at bit 8; the zero byte below catches the last bit shifted out
  assign ext_r = {{W{fill}}, val_p, 8'h00};

  always_comb begin
    for (int i = 0; i < NB_R; i++) begin
      stg_r[8*i +: 8] = ext_r[8*(i + int'(byte_sel)) +: 8];  // byte stage
    end
  end

  assign sh_r = stg_r >> bit_sel;  // bit stage within a byte

  // ====================
  // left shift
  // ====================

  // val_p sits at bit W; the zero byte on top feeds the carry when no byte shift
  assign ext_l = {8'h00, val_p, {W{1'b0}}};

  always_comb begin
    for (int i = 0; i < NB_L; i++) begin
      stg_l[8*i +: 8] = ext_l[8*(i + 8 - int'(byte_sel)) +: 8];
    end
  end

  assign sh_l = stg_l << bit_sel;

  // ====================
  // result and carries
  // ====================

  assign res_raw = dir ? sh_r[W+7:8] : sh_l[W-1:0];

  assign wide_res[W-1:HALF] = en_64 ? res_raw[W-1:HALF] : '0;  // zero-extend 32-bit ops
  assign wide_res[HALF-1:0] = (en_32 | en_64) ? res_raw[HALF-1:0] : '0;

  assign carry_r   = sh_r[7];  // zero when the count is 0
  assign carry_l64 = sh_l[W];
  // bit 32 holds upper-half data when nothing moved
  assign carry_l32 = (cnt_m != '0) & sh_l[HALF];

endmodule

// File: hw/shifter/shift_byte.sv
`timescale 1ns/100ps
`include "shift_macros.svh"

module shift_byte (
  input  logic                      dir,
  input  logic                      arith,
  input  logic [`SHIFT_BYTE_W-1:0]  operand_lo,
  input  logic [`SHIFT_CNT_W-1:0]   cnt_m,
  output logic [`SHIFT_BYTE_W-1:0]  byte_res,
  output logic                      byte_carry_r,
  output logic                      byte_carry_l
);

  localparam int B = `SHIFT_BYTE_W;

  logic            fill;
  logic            big;     // count of 8 or more
  logic            cnt_8;   // count of exactly 8
  logic [2*B:0]    ext_r;
  logic [2*B:0]    sh_r;
  logic [B:0]      ext_l;
  logic [B:0]      sh_l;

  assign fill  = arith & operand_lo[B-1];
  assign big   = |cnt_m[`SHIFT_CNT_W-1:3];
  assign cnt_8 = (cnt_m == 8);

  // ====================
  // small counts
  // ====================

  assign ext_r = {{B{fill}}, operand_lo, 1'b0};  // guard bit 0 takes the carry
  assign sh_r  = ext_r >> cnt_m[2:0];

  assign ext_l = {1'b0, operand_lo};  // bit 8 takes the carry
  assign sh_l  = ext_l << cnt_m[2:0];

  // ====================
  // output select
  // ====================

  always_comb begin
    if (big) begin
      byte_res     = dir ? {B{fill}} : '0;
      // the byte is gone past 8, carry reads the fill-extended operand
      byte_carry_r = cnt_8 ? operand_lo[B-1] : fill;
      byte_carry_l = cnt_8 ? operand_lo[0] : 1'b0;
    end else begin
      byte_res     = dir ? sh_r[B:1] : sh_l[B-1:0];
      byte_carry_r = sh_r[0];  // zero for a count of 0
      byte_carry_l = sh_l[B];
    end
  end

endmodule

// File: hw/shift_result.sv
`timescale 1ns/100ps
`include "shift_macros.svh"

module shift_result (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       in_valid,
  input  shift_unit_pkg::shift_op_e  op,
  input  shift_unit_pkg::op_size_e   size,
  input  logic [`SHIFT_WIDTH-1:0]    wide_res,
  input  logic [`SHIFT_BYTE_W-1:0]   byte_res,
  input  logic                       carry_r,
  input  logic                       carry_l64,
  input  logic                       carry_l32,
  input  logic                       byte_carry_r,
  input  logic                       byte_carry_l,
  output logic                       out_valid,
  output logic [`SHIFT_WIDTH-1:0]    result,
  output logic                       carry,
  output logic                       zero,
  output logic                       sign
);

  logic                     right;
  logic [`SHIFT_WIDTH-1:0]  res_d;
  logic                     carry_d;
  logic                     sign_d;

  assign right = (op != shift_unit_pkg::op_shl);

  // ====================
  // select by size
  // ====================

  always_comb begin
    case (size)
      shift_unit_pkg::size_8: begin
        res_d   = {{(`SHIFT_WIDTH-`SHIFT_BYTE_W){1'b0}}, byte_res};
        carry_d = right ? byte_carry_r : byte_carry_l;
        sign_d  = byte_res[`SHIFT_BYTE_W-1];
      end
      shift_unit_pkg::size_32: begin
        res_d   = wide_res;  // upper half already cleared
        carry_d = right ? carry_r : carry_l32;
        sign_d  = wide_res[`SHIFT_WIDTH/2-1];
      end
      default: begin
        res_d   = wide_res;
        carry_d = right ? carry_r : carry_l64;
        sign_d  = wide_res[`SHIFT_WIDTH-1];
      end
    endcase
  end

  // ====================
  // output register
  // ====================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
      carry     <= 1'b0;
      zero      <= 1'b0;
      sign      <= 1'b0;
    end else begin
      out_valid <= in_valid;  // one-cycle pulse
      if (in_valid) begin
        result <= res_d;
        carry  <= carry_d;
        zero   <= (res_d == '0);
        sign   <= sign_d;
      end
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(out_valid));

  // dword ops come back one cycle later with clean upper bits
  a_upper_32: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && size == shift_unit_pkg::size_32 |=>
      result[`SHIFT_WIDTH-1:`SHIFT_WIDTH/2] == '0);

endmodule

// File: hw/shift_unit_top.sv
`timescale 1ns/100ps
`include "shift_macros.svh"

module shift_unit_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       in_valid,
  input  shift_unit_pkg::shift_op_e  op,
  input  shift_unit_pkg::op_size_e   size,
  input  logic [`SHIFT_WIDTH-1:0]    operand,
  input  logic [`SHIFT_CNT_W-1:0]    count,
  output logic                       out_valid,
  output logic [`SHIFT_WIDTH-1:0]    result,
  output logic                       carry,
  output logic                       zero,
  output logic                       sign
);

  // ====================
  // decode to shifters
  // ====================

  logic                      dir;
  logic                      arith;
  logic                      en_32;
  logic                      en_64;
  logic [`SHIFT_CNT_W-1:0]   cnt_m;

  // shifters to result stage
  logic [`SHIFT_WIDTH-1:0]   wide_res;
  logic                      carry_r;
  logic                      carry_l64;
  logic                      carry_l32;
  logic [`SHIFT_BYTE_W-1:0]  byte_res;
  logic                      byte_carry_r;
  logic                      byte_carry_l;

  shift_decode u_decode (
    .op    (op),
    .size  (size),
    .count (count),
    .dir   (dir),
    .arith (arith),
    .en_32 (en_32),
    .en_64 (en_64),
    .cnt_m (cnt_m)
  );

  shift_wide u_wide (
    .dir       (dir),
    .arith     (arith),
    .en_32     (en_32),
    .en_64     (en_64),
    .operand   (operand),
    .cnt_m     (cnt_m),
    .wide_res  (wide_res),
    .carry_r   (carry_r),
    .carry_l64 (carry_l64),
    .carry_l32 (carry_l32)
  );

  shift_byte u_byte (
    .dir          (dir),
    .arith        (arith),
    .operand_lo   (operand[`SHIFT_BYTE_W-1:0]),  // low byte only
    .cnt_m        (cnt_m),
    .byte_res     (byte_res),
    .byte_carry_r (byte_carry_r),
    .byte_carry_l (byte_carry_l)
  );

  shift_result u_result (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .op           (op),
    .size         (size),
    .wide_res     (wide_res),
    .byte_res     (byte_res),
    .carry_r      (carry_r),
    .carry_l64    (carry_l64),
    .carry_l32    (carry_l32),
    .byte_carry_r (byte_carry_r),
    .byte_carry_l (byte_carry_l),
    .out_valid    (out_valid),
    .result       (result),
    .carry        (carry),
    .zero         (zero),
    .sign         (sign)
  );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;  // release away from the edge
  end

endmodule

// File: dv/shift_unit_tb.sv
`timescale 1ns/100ps
`include "shift_macros.svh"

module shift_unit_tb;

  localparam int N_TESTS      = 6;
  localparam int OPS_PER_TEST = 40;
  localparam int TIMEOUT_NS   = (N_TESTS * OPS_PER_TEST + 20) * 10;

  logic                       clk;
  logic                       arst_n;
  logic                       in_valid;
  shift_unit_pkg::shift_op_e  op;
  shift_unit_pkg::op_size_e   size;
  logic [`SHIFT_WIDTH-1:0]    operand;
  logic [`SHIFT_CNT_W-1:0]    count;
  logic                       out_valid;
  logic [`SHIFT_WIDTH-1:0]    result;
  logic                       carry;
  logic                       zero;
  logic                       sign;

  logic [31:0]                lfsr;
  int                         err_cnt;
  int                         chk_cnt;
  shift_unit_pkg::shift_op_e  all_ops[3];

  tb_clk_gen u_clk (.clk(clk), .arst_n(arst_n));

  shift_unit_top u_dut (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .op(op), .size(size),
    .operand(operand), .count(count), .out_valid(out_valid), .result(result),
    .carry(carry), .zero(zero), .sign(sign)
  );

  // ====================
  // random source and model
  // ====================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic model_shift(input shift_unit_pkg::shift_op_e m_op,
                             input shift_unit_pkg::op_size_e m_size,
                             input logic [63:0] val_in, input logic [5:0] cnt,
                             output logic [63:0] res, output logic c,
                             output logic z, output logic s);
    int          w;
    int          n;
    logic [63:0] val;
    logic        fill;
    w    = (m_size == shift_unit_pkg::size_8) ? 8 : (m_size == shift_unit_pkg::size_32) ? 32 : 64;
    n    = (m_size == shift_unit_pkg::size_64) ? int'(cnt) : int'(cnt[4:0]);  // x86 count mask
    val  = (w == 64) ? val_in : val_in & ((64'd1 << w) - 64'd1);
    fill = (m_op == shift_unit_pkg::op_sar) && val[w-1];
    res  = '0;
    c    = 1'b0;
    for (int i = 0; i < w; i++) begin
      if (m_op == shift_unit_pkg::op_shl) begin
        if (i >= n) res[i] = val[i-n];
      end else if (i + n < w) begin
        res[i] = val[i+n];
      end else begin
        res[i] = fill;
      end
    end
    // last bit out, positions past the operand read as fill
    if (n != 0) begin
      if (m_op == shift_unit_pkg::op_shl) c = (w - n >= 0) ? val[w-n] : 1'b0;
      else c = (n - 1 < w) ? val[n-1] : fill;
    end
    z = (res == '0);
    s = res[w-1];
  endtask

  // ====================
  // compare tasks
  // ====================

  task automatic check_result(input string name, input logic [`SHIFT_WIDTH-1:0] exp,
                              input logic [`SHIFT_WIDTH-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Mismatch in %s: result expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string flag, input logic exp,
                            input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Mismatch in %s: %s expected %b actual %b", name, flag, exp, act);
    end
  endtask

  task automatic compare_outputs(input string name, input shift_unit_pkg::shift_op_e o,
                                 input shift_unit_pkg::op_size_e sz, input logic [63:0] v,
                                 input logic [5:0] n);
    logic [63:0] exp_res;
    logic        exp_c;
    logic        exp_z;
    logic        exp_s;
    model_shift(o, sz, v, n, exp_res, exp_c, exp_z, exp_s);
    check_flag(name, "out_valid", 1'b1, out_valid);
    check_result(name, exp_res, result);
    check_flag(name, "carry", exp_c, carry);
    check_flag(name, "zero", exp_z, zero);
    check_flag(name, "sign", exp_s, sign);
  endtask

  // ====================
  // drivers
  // ====================

  task automatic drive_inputs(input shift_unit_pkg::shift_op_e o,
                              input shift_unit_pkg::op_size_e sz, input logic [63:0] v,
                              input logic [5:0] n);
    op       = o;
    size     = sz;
    operand  = v;
    count    = n;
    in_valid = 1'b1;
  endtask

  // one strobe, result expected exactly one edge later
  task automatic run_op(input string test, input shift_unit_pkg::shift_op_e o,
                        input shift_unit_pkg::op_size_e sz, input logic [63:0] v,
                        input logic [5:0] n);
    string name;
    name = $sformatf("%s %s/%s cnt=%0d", test, o.name(), sz.name(), n);
    @(posedge clk);
    #1;
    drive_inputs(o, sz, v, n);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    compare_outputs(name, o, sz, v, n);
  endtask

  task automatic report_test(input string test, input int errs_before);
    $display("test %-12s done, %0d errors", test, err_cnt - errs_before);
  endtask

  // ====================
  // tests
  // ====================

  task automatic test_reset();
    int e;
    e = err_cnt;
    @(posedge clk);
    #1;
    check_flag("reset", "out_valid", 1'b0, out_valid);
    check_result("reset", '0, result);
    check_flag("reset", "carry", 1'b0, carry);
    check_flag("reset", "zero", 1'b0, zero);
    check_flag("reset", "sign", 1'b0, sign);
    report_test("reset", e);
  endtask

  task automatic test_size(input string test, input shift_unit_pkg::op_size_e sz);
    int          e;
    int          fixed_cnt[4];
    logic [63:0] v;
    logic [63:0] r;
    e = err_cnt;
    case (sz)
      shift_unit_pkg::size_64: fixed_cnt = '{0, 1, 63, 32};
      shift_unit_pkg::size_32: fixed_cnt = '{0, 31, 33, 63};  // 33 acts as 1
      default:                 fixed_cnt = '{8, 9, 31, 40};   // 40 acts as 8
    endcase
    for (int o = 0; o < 3; o++) begin
      for (int k = 0; k < 10; k++) begin
        rand_bits(64, v);
        rand_bits(6, r);
        if (k < 4) r[5:0] = 6'(fixed_cnt[k]);
        if (k[0]) v[7] = 1'b1;  // sign set for byte and dword ops
        if (k[0]) v[31] = 1'b1;
        run_op(test, all_ops[o], sz, v, r[5:0]);
      end
    end
    report_test(test, e);
  endtask

  task automatic test_back_to_back();
    int                         e;
    shift_unit_pkg::shift_op_e  ops[32];
    shift_unit_pkg::op_size_e   sizes[32];
    logic [63:0]                vals[32];
    logic [5:0]                 cnts[32];
    logic [63:0]                r;
    string                      name;
    e = err_cnt;
    for (int i = 0; i < 32; i++) begin
      rand_bits(2, r);
      ops[i] = all_ops[r[1:0] % 2'd3];
      rand_bits(2, r);
      sizes[i] = (r[1:0] == 2'd0) ? shift_unit_pkg::size_8 :
                 (r[1:0] == 2'd1) ? shift_unit_pkg::size_32 : shift_unit_pkg::size_64;
      rand_bits(64, vals[i]);
      rand_bits(6, r);
      cnts[i] = r[5:0];
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < 32; i++) begin
      drive_inputs(ops[i], sizes[i], vals[i], cnts[i]);
      @(posedge clk);
      #1;
      name = $sformatf("b2b[%0d] %s/%s cnt=%0d", i, ops[i].name(), sizes[i].name(), cnts[i]);
      compare_outputs(name, ops[i], sizes[i], vals[i], cnts[i]);
    end
    in_valid = 1'b0;
    report_test("back_to_back", e);
  endtask

  task automatic test_edge();
    int e;
    e = err_cnt;
    run_op("edge", shift_unit_pkg::op_shl, shift_unit_pkg::size_64, 64'h0, 6'd0);
    run_op("edge", shift_unit_pkg::op_sar, shift_unit_pkg::size_64, '1, 6'd0);
    run_op("edge", shift_unit_pkg::op_shr, shift_unit_pkg::size_32, 64'hffff_ffff_0000_0000, 6'd0);
    run_op("edge", shift_unit_pkg::op_shl, shift_unit_pkg::size_8, 64'h1234_5600, 6'd0);
    run_op("edge", shift_unit_pkg::op_sar, shift_unit_pkg::size_64, '1, 6'd17);
    run_op("edge", shift_unit_pkg::op_shr, shift_unit_pkg::size_64, '1, 6'd63);
    run_op("edge", shift_unit_pkg::op_shl, shift_unit_pkg::size_64, 64'h8000_0000_0000_0000, 6'd1);
    run_op("edge", shift_unit_pkg::op_sar, shift_unit_pkg::size_64, 64'h8000_0000_0000_0000, 6'd63);
    run_op("edge", shift_unit_pkg::op_sar, shift_unit_pkg::size_32, 64'h8000_0000, 6'd31);
    run_op("edge", shift_unit_pkg::op_shl, shift_unit_pkg::size_32, 64'h8000_0000, 6'd1);
    run_op("edge", shift_unit_pkg::op_sar, shift_unit_pkg::size_8, 64'h80, 6'd31);
    run_op("edge", shift_unit_pkg::op_shl, shift_unit_pkg::size_8, 64'h80, 6'd1);
    report_test("edge", e);
  endtask

  // ====================
  // main and watchdog
  // ====================

  initial begin
    in_valid   = 1'b0;
    op         = shift_unit_pkg::op_shl;
    size       = shift_unit_pkg::size_64;
    operand    = '0;
    count      = '0;
    lfsr       = 32'h0ca9_25fc;
    err_cnt    = 0;
    chk_cnt    = 0;
    all_ops[0] = shift_unit_pkg::op_shl;
    all_ops[1] = shift_unit_pkg::op_shr;
    all_ops[2] = shift_unit_pkg::op_sar;
    wait (arst_n === 1'b1);
    test_reset();
    test_size("size64", shift_unit_pkg::size_64);
    test_size("size32", shift_unit_pkg::size_32);
    test_size("size8", shift_unit_pkg::size_8);
    test_back_to_back();
    test_edge();
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run timed out after %0d ns", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: shift_unit.f
+incdir+common
common/shift_unit_pkg.sv
hw/shift_decode.sv
hw/shifter/shift_wide.sv
hw/shifter/shift_byte.sv
hw/shift_result.sv
hw/shift_unit_top.sv
dv/tb_clk_gen.sv
dv/shift_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run once, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module shift_unit_tb -f shift_unit.f \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vshift_unit_tb)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
